//--- mem_stage.f
+incdir+hdl
hdl/mem_stage_pkg.sv
hdl/bus_arbiter.sv
hdl/dtlb.sv
hdl/dcache.sv
hdl/lane_align.sv
hdl/mem_stage.sv
test/mem_model.sv
test/mem_stage_tb.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_stage_pkg.sv
      - hdl/bus_arbiter.sv
      - hdl/dtlb.sv
      - hdl/dcache.sv
      - hdl/lane_align.sv
      - hdl/mem_stage.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/mem_model.sv
      - test/mem_stage_tb.sv

//--- test/mem_stage_tb.sv
`default_nettype none

`include "mem_stage_defines.svh"

module mem_stage_tb;
  localparam int MEM_ADDR_BITS = 16;
  localparam logic [63:0] PTBR = 64'h1000;
  localparam int MAX_ACCESSES = 60;
  localparam int MAX_ACCESS_CYCLES = 30;
  localparam int TIMEOUT_CYCLES = MAX_ACCESSES * MAX_ACCESS_CYCLES + 200;

  logic                      clk;
  logic                      reset;
  logic [`MS_XLEN-1:0]       ptbr;
  logic                      req_valid;
  logic                      req_ready;
  mem_stage_pkg::stage_req_t req;
  logic                      rsp_valid;
  logic                      rsp_ready;
  mem_stage_pkg::stage_rsp_t rsp;
  logic                      bus_req_valid;
  logic                      bus_req_ready;
  mem_stage_pkg::bus_req_t   bus_req;
  logic                      bus_rsp_valid;
  mem_stage_pkg::bus_rsp_t   bus_rsp;
  int                        pt_reads;
  int                        data_reads;
  int                        data_writes;
  int                        seed;
  int                        cycles;
  logic [`MS_RD_BITS-1:0]    next_rd;

  mem_stage dut0 (
    .clk, .reset, .ptbr,
    .req_valid, .req_ready, .req,
    .rsp_valid, .rsp_ready, .rsp,
    .bus_req_valid, .bus_req_ready, .bus_req, .bus_rsp_valid, .bus_rsp
  );

  mem_model #(.ADDR_BITS(MEM_ADDR_BITS)) mem0 (
    .clk, .reset, .ptbr,
    .bus_req_valid, .bus_req_ready, .bus_req, .bus_rsp_valid, .bus_rsp,
    .pt_reads, .data_reads, .data_writes
  );

  always #50 clk = ~clk;

  function automatic string rsp_text(input mem_stage_pkg::stage_rsp_t r);
    return $sformatf("rd=%0d data=%h fault=%b", r.rd, r.data, r.fault);
  endfunction

  task automatic check_rsp(input string name, input mem_stage_pkg::stage_rsp_t exp,
                           input mem_stage_pkg::stage_rsp_t got);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %s actual %s", $time, name,
               rsp_text(exp), rsp_text(got));
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_count(input string name, input int exp, input int got);
    if (got != exp) begin
      $display("CHECK FAILED at %0t: %s expected %0d actual %0d", $time, name, exp, got);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_word(input string name, input logic [63:0] exp, input logic [63:0] got);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, got);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %b actual %b", $time, name, exp, got);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  function automatic logic [63:0] fill_pattern(input logic [63:0] addr);
    return {(addr[31:0] * 32'h9e37_79b9) ^ addr[63:32], addr[31:0] ^ 32'hc3a5_5a3c};
  endfunction

  function automatic logic [63:0] vaddr_of(input logic [51:0] vpn, input logic [11:0] off);
    return {vpn, off};
  endfunction

  function automatic logic [63:0] model_word(input logic [63:0] paddr);
    return mem0.mem[paddr[MEM_ADDR_BITS-1:3]];
  endfunction

  // Walks the page table held in the model
  function automatic logic [63:0] phys_addr(input logic [63:0] vaddr);
    logic [63:0] pte;
    pte = model_word(PTBR + {vaddr[63:12], 3'b000});
    return {pte[63:12], vaddr[11:0]};
  endfunction

  function automatic int access_bytes(input mem_stage_pkg::mem_op_e op);
    case (op)
      mem_stage_pkg::OP_LB, mem_stage_pkg::OP_LBU, mem_stage_pkg::OP_SB: return 1;
      mem_stage_pkg::OP_LH, mem_stage_pkg::OP_LHU, mem_stage_pkg::OP_SH: return 2;
      mem_stage_pkg::OP_LW, mem_stage_pkg::OP_LWU, mem_stage_pkg::OP_SW: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic logic [63:0] expect_load(input mem_stage_pkg::mem_op_e op,
                                              input logic [63:0] word, input int off);
    logic [63:0] val;
    logic [63:0] mask;
    int n;
    n = access_bytes(op);
    val = word >> (8 * off);
    if (n < 8) begin
      mask = (64'd1 << (8 * n)) - 64'd1;
      val = val & mask;
      if (!(op inside {mem_stage_pkg::OP_LBU, mem_stage_pkg::OP_LHU, mem_stage_pkg::OP_LWU})
          && val[8*n-1]) val = val | ~mask;
    end
    return val;
  endfunction

  function automatic logic [63:0] expect_store(input mem_stage_pkg::mem_op_e op,
                                               input logic [63:0] old, input logic [63:0] data,
                                               input int off);
    logic [63:0] res;
    res = old;
    for (int i = 0; i < access_bytes(op); i++) res[8*(off+i) +: 8] = data[8*i +: 8];
    return res;
  endfunction

  task automatic fill_memory();
    for (int i = 0; i < 2**(MEM_ADDR_BITS-3); i++) mem0.mem[i] = fill_pattern(64'(i) << 3);
    mem0.mem[(PTBR >> 3) + 64'h10] = {52'h4, 11'b0, 1'b1};
    mem0.mem[(PTBR >> 3) + 64'h11] = {52'h5, 11'b0, 1'b1};
    mem0.mem[(PTBR >> 3) + 64'h12] = {52'h9, 11'b0, 1'b0};   // Invalid entry
    mem0.mem[(PTBR >> 3) + 64'h13] = {52'h9, 11'b0, 1'b1};
    mem0.mem[(PTBR >> 3) + 64'h14] = {52'h6, 11'b0, 1'b1};
    mem0.mem[(PTBR >> 3) + 64'h18] = {52'h7, 11'b0, 1'b1};
    mem0.mem[(PTBR >> 3) + 64'h1c] = {52'h8, 11'b0, 1'b1};
  endtask

  task automatic send_req(input mem_stage_pkg::mem_op_e op, input logic [63:0] vaddr,
                          input logic [63:0] wdata, input logic [4:0] rd);
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    req_valid = 1'b1;
    req = '{op: op, vaddr: vaddr, wdata: wdata, rd: rd};
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic wait_rsp(output mem_stage_pkg::stage_rsp_t got);
    while (!rsp_valid) @(negedge clk);
    got = rsp;
  endtask

  task automatic run_access(input mem_stage_pkg::mem_op_e op, input logic [63:0] vaddr,
                            input logic [63:0] wdata, output mem_stage_pkg::stage_rsp_t got,
                            output logic [4:0] rd);
    rd = next_rd;
    next_rd = next_rd + 1'b1;
    send_req(op, vaddr, wdata, rd);
    wait_rsp(got);
  endtask

  task automatic load_and_check(input string name, input mem_stage_pkg::mem_op_e op,
                                input logic [63:0] vaddr);
    mem_stage_pkg::stage_rsp_t got;
    mem_stage_pkg::stage_rsp_t exp;
    logic [4:0] rd;
    logic [63:0] word;
    word = model_word(phys_addr(vaddr));
    run_access(op, vaddr, '0, got, rd);
    exp = '{rd: rd, data: expect_load(op, word, int'(vaddr[2:0])), fault: 1'b0};
    check_rsp(name, exp, got);
  endtask

  task automatic store_and_check(input mem_stage_pkg::mem_op_e op, input logic [63:0] vaddr,
                                 input logic [63:0] data);
    mem_stage_pkg::stage_rsp_t got;
    logic [4:0] rd;
    logic [63:0] old;
    logic [63:0] pa;
    pa = phys_addr(vaddr);
    old = model_word(pa);
    run_access(op, vaddr, data, got, rd);
    check_rsp("store response", '{rd: rd, data: '0, fault: 1'b0}, got);
    check_word("memory word", expect_store(op, old, data, int'(vaddr[2:0])), model_word(pa));
  endtask

  task automatic expect_fault(input mem_stage_pkg::mem_op_e op, input logic [63:0] vaddr);
    mem_stage_pkg::stage_rsp_t got;
    logic [4:0] rd;
    run_access(op, vaddr, 64'h1234_5678_9abc_def0, got, rd);
    check_rsp("fault response", '{rd: rd, data: '0, fault: 1'b1}, got);
  endtask

  task automatic test_load_widths();
    mem_stage_pkg::mem_op_e op;
    int n;
    int base_pt;
    int base_rd;
    base_pt = pt_reads;
    base_rd = data_reads;
    for (int k = 0; k < 7; k++) begin
      op = mem_stage_pkg::mem_op_e'(k);
      n = access_bytes(op);
      for (int off = 0; off < 8; off += n) begin
        load_and_check("load data", op, vaddr_of(52'h10, 12'(12'h040 + off)));
      end
    end
    check_count("page-table reads", 1, pt_reads - base_pt);
    check_count("data reads", 1, data_reads - base_rd);   // One fill, then hits
  endtask

  task automatic test_store_merge();
    mem_stage_pkg::mem_op_e op;
    logic [63:0] va;
    logic [63:0] data;
    int n;
    int r;
    for (int k = 0; k < 4; k++) begin
      op = mem_stage_pkg::mem_op_e'(7 + k);
      n = access_bytes(op);
      r = $random(seed) & 7;
      r = r - (r % n);
      data = {$random(seed), $random(seed)};
      va = vaddr_of(52'h11, 12'(12'h100 + 8 * k + r));
      store_and_check(op, va, data);
      load_and_check("merged word", mem_stage_pkg::OP_LD, va & ~64'h7);
    end
  endtask

  task automatic test_tlb_reuse();
    int base_pt;
    base_pt = pt_reads;
    load_and_check("same page", mem_stage_pkg::OP_LD, vaddr_of(52'h10, 12'h080));
    check_count("page-table reads, same page", 0, pt_reads - base_pt);
    load_and_check("alias page", mem_stage_pkg::OP_LD, vaddr_of(52'h14, 12'h080));
    load_and_check("alias page", mem_stage_pkg::OP_LD, vaddr_of(52'h18, 12'h080));
    load_and_check("alias page", mem_stage_pkg::OP_LD, vaddr_of(52'h1c, 12'h080));
    load_and_check("alias page", mem_stage_pkg::OP_LD, vaddr_of(52'h10, 12'h080));
    check_count("page-table reads, aliased pages", 4, pt_reads - base_pt);
  endtask

  task automatic test_cache();
    logic [63:0] va_a;
    logic [63:0] va_b;
    int base_rd;
    int base_wr;
    va_a = vaddr_of(52'h13, 12'h200);
    va_b = vaddr_of(52'h13, 12'h304);   // Same line index as va_a
    base_rd = data_reads;
    load_and_check("repeat load", mem_stage_pkg::OP_LD, va_a);
    load_and_check("repeat load", mem_stage_pkg::OP_LD, va_a);
    check_count("data reads, repeated load", 1, data_reads - base_rd);
    base_rd = data_reads;
    base_wr = data_writes;
    store_and_check(mem_stage_pkg::OP_SD, va_a, {$random(seed), $random(seed)});
    check_count("data writes, store hit", 1, data_writes - base_wr);
    load_and_check("load after store hit", mem_stage_pkg::OP_LD, va_a);
    check_count("data reads, store hit", 0, data_reads - base_rd);
    base_rd = data_reads;
    store_and_check(mem_stage_pkg::OP_SW, va_b, {$random(seed), $random(seed)});
    load_and_check("load after store miss", mem_stage_pkg::OP_LD, va_b & ~64'h7);
    check_count("data reads, store miss", 1, data_reads - base_rd);
  endtask

  task automatic test_faults();
    int base_pt;
    int base_rd;
    int base_wr;
    base_pt = pt_reads;
    base_rd = data_reads;
    base_wr = data_writes;
    expect_fault(mem_stage_pkg::OP_LH, vaddr_of(52'h10, 12'h041));
    expect_fault(mem_stage_pkg::OP_LW, vaddr_of(52'h10, 12'h042));
    expect_fault(mem_stage_pkg::OP_LD, vaddr_of(52'h10, 12'h044));
    expect_fault(mem_stage_pkg::OP_SH, vaddr_of(52'h10, 12'h043));
    expect_fault(mem_stage_pkg::OP_SW, vaddr_of(52'h10, 12'h045));
    expect_fault(mem_stage_pkg::OP_SD, vaddr_of(52'h10, 12'h046));
    check_count("page-table reads, misaligned", 0, pt_reads - base_pt);
    expect_fault(mem_stage_pkg::OP_LD, vaddr_of(52'h12, 12'h010));
    expect_fault(mem_stage_pkg::OP_SW, vaddr_of(52'h12, 12'h020));
    check_count("page-table reads, invalid entry", 2, pt_reads - base_pt);   // Not cached
    check_count("data reads, faults", 0, data_reads - base_rd);
    check_count("data writes, faults", 0, data_writes - base_wr);
  endtask

  task automatic test_backpressure();
    mem_stage_pkg::stage_rsp_t held;
    logic [4:0] rd;
    logic [63:0] va;
    logic [63:0] word;
    va = vaddr_of(52'h10, 12'h048);
    word = model_word(phys_addr(va));
    rd = next_rd;
    next_rd = next_rd + 1'b1;
    @(negedge clk);   // Previous response taken
    rsp_ready = 1'b0;
    send_req(mem_stage_pkg::OP_LD, va, '0, rd);
    wait_rsp(held);
    check_rsp("held response", '{rd: rd, data: word, fault: 1'b0}, held);
    repeat (6) begin
      @(negedge clk);
      check_flag("rsp_valid", 1'b1, rsp_valid);
      check_flag("req_ready", 1'b0, req_ready);
      check_rsp("rsp while stalled", held, rsp);
    end
    rsp_ready = 1'b1;
    @(negedge clk);
    check_flag("rsp_valid after release", 1'b0, rsp_valid);
    check_flag("req_ready after release", 1'b1, req_ready);
  endtask

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the DUT never answered", cycles);
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    seed = 32'haaa55a9c;
    clk = 1'b0;
    reset = 1'b1;
    ptbr = PTBR;
    req_valid = 1'b0;
    req = '0;
    rsp_ready = 1'b1;
    next_rd = 5'd1;
    fill_memory();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_load_widths();
    test_store_merge();
    test_tlb_reuse();
    test_cache();
    test_faults();
    test_backpressure();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/mem_model.sv
`default_nettype none

`include "mem_stage_defines.svh"

module mem_model #(
  parameter int ADDR_BITS = 16   // Byte address bits decoded
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire [`MS_XLEN-1:0]           ptbr,
  input  wire                          bus_req_valid,
  output logic                         bus_req_ready,
  input  wire mem_stage_pkg::bus_req_t bus_req,
  output logic                         bus_rsp_valid,
  output mem_stage_pkg::bus_rsp_t      bus_rsp,
  output int                           pt_reads,
  output int                           data_reads,
  output int                           data_writes
);
  logic [`MS_XLEN-1:0]  mem [2**(ADDR_BITS-3)];
  logic                 busy;
  logic                 delay;   // First wait cycle
  logic [`MS_XLEN-1:0]  rdata_q;
  logic [`MS_XLEN-1:0]  merged;
  logic [ADDR_BITS-4:0] widx;

  assign widx = bus_req.addr[ADDR_BITS-1:3];
  assign bus_req_ready = !busy;

  always @(posedge clk) begin
    bus_rsp_valid <= 1'b0;
    if (reset) begin
      busy <= 1'b0;
      delay <= 1'b0;
      bus_rsp <= '0;
      pt_reads <= 0;
      data_reads <= 0;
      data_writes <= 0;
    end else if (!busy) begin
      if (bus_req_valid) begin
        busy <= 1'b1;
        delay <= 1'b1;
        rdata_q <= bus_req.write ? '0 : mem[widx];   // Writes answer without data
        if (bus_req.write) begin
          merged = mem[widx];
          for (int i = 0; i < 8; i++) begin
            if (bus_req.strb[i]) merged[8*i +: 8] = bus_req.wdata[8*i +: 8];
          end
          mem[widx] <= merged;
          data_writes <= data_writes + 1;
        end else if (bus_req.addr[`MS_XLEN-1:`MS_PAGE_BITS] ==
                     ptbr[`MS_XLEN-1:`MS_PAGE_BITS]) begin
          pt_reads <= pt_reads + 1;
        end else begin
          data_reads <= data_reads + 1;
        end
      end
    end else if (delay) begin
      delay <= 1'b0;
    end else begin
      busy <= 1'b0;
      bus_rsp_valid <= 1'b1;   // Two cycles after acceptance
      bus_rsp <= '{rdata: rdata_q};
    end
  end

endmodule

`default_nettype wire

//--- hdl/mem_stage.sv
`default_nettype none

`include "mem_stage_defines.svh"

module mem_stage (
  input  wire                            clk,
  input  wire                            reset,
  input  wire [`MS_XLEN-1:0]             ptbr,
  input  wire                            req_valid,
  output logic                           req_ready,
  input  wire mem_stage_pkg::stage_req_t req,
  output logic                           rsp_valid,
  input  wire                            rsp_ready,
  output mem_stage_pkg::stage_rsp_t      rsp,
  output logic                           bus_req_valid,
  input  wire                            bus_req_ready,
  output mem_stage_pkg::bus_req_t        bus_req,
  input  wire                            bus_rsp_valid,
  input  wire mem_stage_pkg::bus_rsp_t   bus_rsp
);
  typedef enum logic [1:0] {ST_IDLE, ST_XLATE, ST_ACCESS, ST_RESP} stage_state_e;

  stage_state_e                       state;
  logic                               start;   // First cycle of translate or access
  mem_stage_pkg::stage_req_t          req_q;
  mem_stage_pkg::stage_rsp_t          rsp_q;
  logic                               misaligned;
  logic                               is_store;
  logic                               xlat_done;
  logic                               xlat_fault;
  logic [`MS_XLEN-`MS_PAGE_BITS-1:0]  ppn;
  logic                               acc_done;
  logic [`MS_XLEN-1:0]                cache_rdata;
  logic [`MS_XLEN-1:0]                load_data;
  logic [`MS_XLEN-1:0]                store_word;
  logic [7:0]                         store_strb;
  logic                               tlb_req_valid, tlb_req_ready, tlb_rsp_valid;
  logic                               cache_req_valid, cache_req_ready, cache_rsp_valid;
  mem_stage_pkg::bus_req_t            tlb_req, cache_req;

  always_comb begin
    case (req.op)
      mem_stage_pkg::OP_LH, mem_stage_pkg::OP_LHU, mem_stage_pkg::OP_SH:
        misaligned = req.vaddr[0];
      mem_stage_pkg::OP_LW, mem_stage_pkg::OP_LWU, mem_stage_pkg::OP_SW:
        misaligned = (req.vaddr[1:0] != 2'b00);
      mem_stage_pkg::OP_LD, mem_stage_pkg::OP_SD:
        misaligned = (req.vaddr[2:0] != 3'b000);
      default: misaligned = 1'b0;
    endcase
  end

  assign is_store = req_q.op inside {mem_stage_pkg::OP_SB, mem_stage_pkg::OP_SH,
                                     mem_stage_pkg::OP_SW, mem_stage_pkg::OP_SD};
  assign req_ready = (state == ST_IDLE);
  assign rsp_valid = (state == ST_RESP);
  assign rsp = rsp_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      start <= 1'b0;
    end else begin
      start <= 1'b0;
      case (state)
        ST_IDLE: if (req_valid) begin
          state <= misaligned ? ST_RESP : ST_XLATE;   // Misaligned skips the bus
          start <= !misaligned;
        end
        ST_XLATE: if (xlat_done) begin
          state <= xlat_fault ? ST_RESP : ST_ACCESS;
          start <= !xlat_fault;
        end
        ST_ACCESS: if (acc_done) state <= ST_RESP;
        ST_RESP: if (rsp_ready) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req_valid) begin
      req_q <= req;
      rsp_q <= '{rd: req.rd, data: '0, fault: misaligned};
    end
    if (state == ST_XLATE && xlat_done) rsp_q.fault <= xlat_fault;
    if (state == ST_ACCESS && acc_done && !is_store) rsp_q.data <= load_data;
  end

  dtlb dtlb0 (
    .clk, .reset, .ptbr,
    .xlat_valid(state == ST_XLATE && start),
    .vpn(req_q.vaddr[`MS_XLEN-1:`MS_PAGE_BITS]),
    .xlat_done, .ppn, .xlat_fault,
    .bus_req_valid(tlb_req_valid), .bus_req_ready(tlb_req_ready), .bus_req(tlb_req),
    .bus_rsp_valid(tlb_rsp_valid), .bus_rsp
  );

  dcache dcache0 (
    .clk, .reset,
    .acc_valid(state == ST_ACCESS && start),
    .paddr({ppn, req_q.vaddr[`MS_PAGE_BITS-1:0]}),
    .write(is_store), .wdata(store_word), .strb(store_strb),
    .acc_done, .rdata(cache_rdata),
    .bus_req_valid(cache_req_valid), .bus_req_ready(cache_req_ready), .bus_req(cache_req),
    .bus_rsp_valid(cache_rsp_valid), .bus_rsp
  );

  lane_align lane_align0 (
    .op(req_q.op), .offset(req_q.vaddr[2:0]), .line_word(cache_rdata),
    .store_data(req_q.wdata), .load_data, .store_word, .store_strb
  );

  bus_arbiter bus_arbiter0 (
    .clk, .reset,
    .tlb_req_valid, .tlb_req_ready, .tlb_req, .tlb_rsp_valid,
    .cache_req_valid, .cache_req_ready, .cache_req, .cache_rsp_valid,
    .bus_req_valid, .bus_req_ready, .bus_req, .bus_rsp_valid
  );

  a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

`default_nettype wire

//--- hdl/lane_align.sv
`default_nettype none

`include "mem_stage_defines.svh"

module lane_align (
  input  wire mem_stage_pkg::mem_op_e op,
  input  wire [2:0]                   offset,
  input  wire [`MS_XLEN-1:0]          line_word,
  input  wire [`MS_XLEN-1:0]          store_data,
  output logic [`MS_XLEN-1:0]         load_data,
  output logic [`MS_XLEN-1:0]         store_word,
  output logic [7:0]                  store_strb
);
  logic [`MS_XLEN-1:0] shifted;

  assign shifted = line_word >> {offset, 3'b000};   // Addressed byte to lane 0

  always_comb begin
    load_data = '0;
    store_word = store_data;
    store_strb = '0;
    case (op)
      mem_stage_pkg::OP_LB:  load_data = {{(`MS_XLEN-8){shifted[7]}}, shifted[7:0]};
      mem_stage_pkg::OP_LBU: load_data = {{(`MS_XLEN-8){1'b0}}, shifted[7:0]};
      mem_stage_pkg::OP_LH:  load_data = {{(`MS_XLEN-16){shifted[15]}}, shifted[15:0]};
      mem_stage_pkg::OP_LHU: load_data = {{(`MS_XLEN-16){1'b0}}, shifted[15:0]};
      mem_stage_pkg::OP_LW:  load_data = {{(`MS_XLEN-32){shifted[31]}}, shifted[31:0]};
      mem_stage_pkg::OP_LWU: load_data = {{(`MS_XLEN-32){1'b0}}, shifted[31:0]};
      mem_stage_pkg::OP_LD:  load_data = line_word;
      mem_stage_pkg::OP_SB: begin
        store_word = {8{store_data[7:0]}};
        store_strb = 8'b0000_0001 << offset;
      end
      mem_stage_pkg::OP_SH: begin
        store_word = {4{store_data[15:0]}};
        store_strb = 8'b0000_0011 << offset;
      end
      mem_stage_pkg::OP_SW: begin
        store_word = {2{store_data[31:0]}};
        store_strb = 8'b0000_1111 << offset;
      end
      mem_stage_pkg::OP_SD: store_strb = 8'hff;
      default: load_data = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/dcache.sv
`default_nettype none

`include "mem_stage_defines.svh"

module dcache (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          acc_valid,
  input  wire [`MS_XLEN-1:0]           paddr,
  input  wire                          write,
  input  wire [`MS_XLEN-1:0]           wdata,
  input  wire [7:0]                    strb,
  output logic                         acc_done,
  output logic [`MS_XLEN-1:0]          rdata,
  output logic                         bus_req_valid,
  input  wire                          bus_req_ready,
  output mem_stage_pkg::bus_req_t      bus_req,
  input  wire                          bus_rsp_valid,
  input  wire mem_stage_pkg::bus_rsp_t bus_rsp
);
  localparam int IDX_W = $clog2(`MS_CACHE_LINES);
  localparam int TAG_W = `MS_XLEN - IDX_W - 3;

  typedef enum logic [1:0] {C_IDLE, C_REQ, C_WAIT} cache_state_e;

  cache_state_e               state;
  logic [`MS_CACHE_LINES-1:0] line_valid;
  logic [TAG_W-1:0]           line_tag [`MS_CACHE_LINES];
  logic [`MS_XLEN-1:0]        line_data [`MS_CACHE_LINES];
  logic [`MS_XLEN-4:0]        word_q;   // Word address of the pending access
  logic                       write_q;
  logic [`MS_XLEN-1:0]        wdata_q;
  logic [7:0]                 strb_q;
  logic [IDX_W-1:0]           idx;
  logic [IDX_W-1:0]           idx_q;
  logic                       hit;
  logic [`MS_XLEN-1:0]        merged;

  assign idx = paddr[IDX_W+2:3];
  assign idx_q = word_q[IDX_W-1:0];
  assign hit = line_valid[idx] && (line_tag[idx] == paddr[`MS_XLEN-1:IDX_W+3]);

  always_comb begin
    merged = line_data[idx];
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) merged[8*i +: 8] = wdata[8*i +: 8];
    end
  end

  // Stores always go to memory, reads fetch the whole word
  assign bus_req_valid = (state == C_REQ);
  assign bus_req = '{addr: {word_q, 3'b000}, write: write_q, wdata: wdata_q,
                     strb: write_q ? strb_q : 8'hff};

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= C_IDLE;
      line_valid <= '0;
      acc_done <= 1'b0;
    end else begin
      acc_done <= 1'b0;
      case (state)
        C_IDLE: if (acc_valid) begin
          if (!write && hit) acc_done <= 1'b1;
          else state <= C_REQ;
        end
        C_REQ: if (bus_req_ready) state <= C_WAIT;
        C_WAIT: if (bus_rsp_valid) begin
          state <= C_IDLE;
          acc_done <= 1'b1;
          if (!write_q) line_valid[idx_q] <= 1'b1;   // No allocate on store miss
        end
        default: state <= C_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == C_IDLE && acc_valid) begin
      word_q <= paddr[`MS_XLEN-1:3];
      write_q <= write;
      wdata_q <= wdata;
      strb_q <= strb;
      rdata <= line_data[idx];
      if (write && hit) line_data[idx] <= merged;
    end
    if (state == C_WAIT && bus_rsp_valid && !write_q) begin
      line_data[idx_q] <= bus_rsp.rdata;
      line_tag[idx_q] <= word_q[`MS_XLEN-4:IDX_W];
      rdata <= bus_rsp.rdata;
    end
  end

  a_bus_after_acc: assert property (@(posedge clk) disable iff (reset)
    bus_req_valid && !$past(bus_req_valid) |-> $past(acc_valid));

endmodule

`default_nettype wire

//--- hdl/dtlb.sv
`default_nettype none

`include "mem_stage_defines.svh"

module dtlb (
  input  wire                                    clk,
  input  wire                                    reset,
  input  wire [`MS_XLEN-1:0]                     ptbr,
  input  wire                                    xlat_valid,
  input  wire [`MS_XLEN-`MS_PAGE_BITS-1:0]       vpn,
  output logic                                   xlat_done,
  output logic [`MS_XLEN-`MS_PAGE_BITS-1:0]      ppn,
  output logic                                   xlat_fault,
  output logic                                   bus_req_valid,
  input  wire                                    bus_req_ready,
  output mem_stage_pkg::bus_req_t                bus_req,
  input  wire                                    bus_rsp_valid,
  input  wire mem_stage_pkg::bus_rsp_t           bus_rsp
);
  localparam int VPN_W = `MS_XLEN - `MS_PAGE_BITS;
  localparam int IDX_W = $clog2(`MS_TLB_ENTRIES);
  localparam int TAG_W = VPN_W - IDX_W;

  typedef enum logic [1:0] {W_IDLE, W_REQ, W_WAIT} walk_state_e;

  walk_state_e                state;
  logic [`MS_TLB_ENTRIES-1:0] ent_valid;
  logic [TAG_W-1:0]           ent_tag [`MS_TLB_ENTRIES];
  logic [VPN_W-1:0]           ent_ppn [`MS_TLB_ENTRIES];
  logic [VPN_W-1:0]           vpn_q;
  logic [IDX_W-1:0]           idx;
  logic [IDX_W-1:0]           idx_q;
  logic                       hit;
  logic                       pte_ok;

  assign idx = vpn[IDX_W-1:0];
  assign idx_q = vpn_q[IDX_W-1:0];
  assign hit = ent_valid[idx] && (ent_tag[idx] == vpn[VPN_W-1:IDX_W]);
  assign pte_ok = bus_rsp.rdata[`MS_PTE_VALID_BIT];

  // One PTE read at ptbr + 8 * vpn
  assign bus_req_valid = (state == W_REQ);
  assign bus_req = '{addr: ptbr + {vpn_q, 3'b000}, write: 1'b0, wdata: '0, strb: '0};

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= W_IDLE;
      ent_valid <= '0;
      xlat_done <= 1'b0;
      xlat_fault <= 1'b0;
    end else begin
      xlat_done <= 1'b0;
      case (state)
        W_IDLE: if (xlat_valid) begin
          if (hit) begin
            xlat_done <= 1'b1;
            xlat_fault <= 1'b0;
          end else begin
            state <= W_REQ;
          end
        end
        W_REQ: if (bus_req_ready) state <= W_WAIT;
        W_WAIT: if (bus_rsp_valid) begin
          state <= W_IDLE;
          xlat_done <= 1'b1;
          xlat_fault <= !pte_ok;
          if (pte_ok) ent_valid[idx_q] <= 1'b1;   // Invalid PTE is not kept
        end
        default: state <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == W_IDLE && xlat_valid) begin
      vpn_q <= vpn;
      ppn <= ent_ppn[idx];
    end
    if (state == W_WAIT && bus_rsp_valid) begin
      ppn <= bus_rsp.rdata[`MS_XLEN-1:`MS_PPN_LSB];
      if (pte_ok) begin
        ent_tag[idx_q] <= vpn_q[VPN_W-1:IDX_W];
        ent_ppn[idx_q] <= bus_rsp.rdata[`MS_XLEN-1:`MS_PPN_LSB];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         tlb_req_valid,
  output logic                        tlb_req_ready,
  input  wire mem_stage_pkg::bus_req_t tlb_req,
  output logic                        tlb_rsp_valid,
  input  wire                         cache_req_valid,
  output logic                        cache_req_ready,
  input  wire mem_stage_pkg::bus_req_t cache_req,
  output logic                        cache_rsp_valid,
  output logic                        bus_req_valid,
  input  wire                         bus_req_ready,
  output mem_stage_pkg::bus_req_t     bus_req,
  input  wire                         bus_rsp_valid
);
  logic busy;     // Owner locked
  logic issued;   // Request accepted, awaiting response
  logic owner;    // 1 = cache
  logic prio;     // Cache wins a tie when set
  logic pick_cache;

  assign pick_cache = cache_req_valid && (!tlb_req_valid || prio);

  assign bus_req = owner ? cache_req : tlb_req;
  assign bus_req_valid = busy && !issued && (owner ? cache_req_valid : tlb_req_valid);
  assign tlb_req_ready = busy && !issued && !owner && bus_req_ready;
  assign cache_req_ready = busy && !issued && owner && bus_req_ready;
  assign tlb_rsp_valid = issued && !owner && bus_rsp_valid;
  assign cache_rsp_valid = issued && owner && bus_rsp_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      issued <= 1'b0;
      owner <= 1'b0;
      prio <= 1'b0;
    end else if (!busy) begin
      if (tlb_req_valid || cache_req_valid) begin
        busy <= 1'b1;
        owner <= pick_cache;
      end
    end else if (!issued) begin
      if (bus_req_valid && bus_req_ready) issued <= 1'b1;
    end else if (bus_rsp_valid) begin
      busy <= 1'b0;
      issued <= 1'b0;
      prio <= !owner;   // Alternate after each transfer
    end
  end

  // Each bus response belongs to exactly one granted requester
  a_one_grant: assert property (@(posedge clk) disable iff (reset)
    bus_rsp_valid |-> $onehot({tlb_rsp_valid, cache_rsp_valid}));

endmodule

`default_nettype wire

//--- hdl/mem_stage_pkg.sv
`default_nettype none

`include "mem_stage_defines.svh"

package mem_stage_pkg;

  typedef enum logic [3:0] {
    OP_LB,
    OP_LBU,
    OP_LH,
    OP_LHU,
    OP_LW,
    OP_LWU,
    OP_LD,
    OP_SB,
    OP_SH,
    OP_SW,
    OP_SD
  } mem_op_e;

  typedef struct packed {
    mem_op_e                 op;
    logic [`MS_XLEN-1:0]     vaddr;
    logic [`MS_XLEN-1:0]     wdata;   // Store value, low bytes used
    logic [`MS_RD_BITS-1:0]  rd;
  } stage_req_t;

  typedef struct packed {
    logic [`MS_RD_BITS-1:0]  rd;
    logic [`MS_XLEN-1:0]     data;    // Zero for stores and faults
    logic                    fault;
  } stage_rsp_t;

  typedef struct packed {
    logic [`MS_XLEN-1:0]     addr;    // Word aligned
    logic                    write;
    logic [`MS_XLEN-1:0]     wdata;
    logic [7:0]              strb;
  } bus_req_t;

  typedef struct packed {
    logic [`MS_XLEN-1:0]     rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

//--- hdl/mem_stage_defines.svh
`ifndef MEM_STAGE_DEFINES_SVH
`define MEM_STAGE_DEFINES_SVH

// Data and address width
`define MS_XLEN 64

// Page offset width, 4 KiB pages
`define MS_PAGE_BITS 12

`define MS_TLB_ENTRIES 4
`define MS_CACHE_LINES 8

// Destination register number width
`define MS_RD_BITS 5

// Page-table entry layout
`define MS_PTE_VALID_BIT 0
`define MS_PPN_LSB 12

`endif
